//--- sim.f
logic/btb_pkg.sv
logic/btb_ctrl.sv
logic/btb_refill_buf.sv
logic/btb_way_array.sv
logic/btb_read_out.sv
logic/btb_top.sv
testbench/btb_assertions.sv
testbench/btb_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = btb_tb
FILELIST  = sim.f
LOG       = sim.log
PASS_MSG  = No errors
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/btb_vectors.txt
# op test f0 f1 f2, then per way 0..3: vld tag pred target (hex)
# U idx tag target, P pred stall, M miss, R idx, H idx cycles, E en, I inv, C idle check
C 1 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
I 1 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 1 3 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 1 a 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
U 2 5 0a6 12345 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
P 2 1 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
M 2 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 2 5 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 1 0a6 1 12345
H 3 9 4 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 1 0a6 1 12345
U 4 7 0b2 0abcd 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
P 4 2 1 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
M 4 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 4 7 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 5 5 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 1 0a6 1 12345
E 5 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 5 5 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 0a6 1 12345
U 5 c 0a4 11111 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
P 5 3 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
M 5 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
E 5 1 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 5 c 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 5 5 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 1 0a6 1 12345
U 6 2 0a0 00aaa 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
P 6 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
M 6 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
U 6 e 0b4 0bbbb 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
P 6 2 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
M 6 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 6 2 0 0 1 0a0 0 00aaa 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 6 e 0 0 0 000 0 00000 0 000 0 00000 1 0b4 2 0bbbb 0 000 0 00000
I 6 0 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 6 2 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 6 e 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000
R 6 5 0 0 0 000 0 00000 0 000 0 00000 0 000 0 00000 0 000 0 00000

//--- testbench/btb_tb.sv
// Testbench of the branch target buffer driven line by line from a vector file
// Read, hold and idle lines carry the expected result of all four ways
`timescale 1ns/1ps
`default_nettype none

module btb_tb;

    import btb_pkg::*;

    localparam int    INDEX_W  = 4;
    localparam int    SETS     = 2 ** INDEX_W;
    localparam string VEC_FILE = "testbench/btb_vectors.txt";

    logic                    refill_buf_updt_clk;
    logic                    cpurst_b;
    logic                    cp0_ifu_btb_en;
    logic                    pcgen_btb_stall;
    logic                    ibdp_btb_miss;
    logic                    ifctrl_btb_inv;
    logic                    addrgen_btb_update_vld;
    logic [INDEX_W-1:0]      pcgen_btb_index;
    logic [INDEX_W-1:0]      addrgen_btb_index;
    refill_t                 addrgen_btb_update;
    logic [PRED_W-1:0]       ipctrl_btb_way_pred;
    btb_way_t [NUM_WAYS-1:0] btb_ifdp_way;
    logic                    btb_ifctrl_inv_on;
    logic                    btb_ifctrl_inv_done;

    int   checks;
    int   errors;
    int   test_errors;
    int   cur_test;
    logic timed_out;

    btb_top #(
        .INDEX_W (INDEX_W)
    ) i_btb_top (
        .refill_buf_updt_clk    (refill_buf_updt_clk),
        .cpurst_b               (cpurst_b),
        .cp0_ifu_btb_en         (cp0_ifu_btb_en),
        .pcgen_btb_stall        (pcgen_btb_stall),
        .ibdp_btb_miss          (ibdp_btb_miss),
        .ifctrl_btb_inv         (ifctrl_btb_inv),
        .addrgen_btb_update_vld (addrgen_btb_update_vld),
        .pcgen_btb_index        (pcgen_btb_index),
        .addrgen_btb_index      (addrgen_btb_index),
        .addrgen_btb_update     (addrgen_btb_update),
        .ipctrl_btb_way_pred    (ipctrl_btb_way_pred),
        .btb_ifdp_way           (btb_ifdp_way),
        .btb_ifctrl_inv_on      (btb_ifctrl_inv_on),
        .btb_ifctrl_inv_done    (btb_ifctrl_inv_done)
    );

    // 20 ns period
    always #10 refill_buf_updt_clk = ~refill_buf_updt_clk;

    //==========================================================================
    //                          Compare tasks
    //==========================================================================
    task automatic compare_way(input string name, input btb_way_t exp, input btb_way_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_ways(input btb_way_t [NUM_WAYS-1:0] exp);
        for (int w = 0; w < NUM_WAYS; w++) begin
            compare_way($sformatf("btb_ifdp_way[%0d]", w), exp[w], btb_ifdp_way[w]);
        end
    endtask

    //==========================================================================
    //                          Operations
    //==========================================================================
    // All tasks start and end just after a rising edge

    // Outputs without a new read while the sweep is idle
    task automatic check_idle(input btb_way_t [NUM_WAYS-1:0] exp);
        @(negedge refill_buf_updt_clk);
        compare_level("btb_ifctrl_inv_on", 1'b0, btb_ifctrl_inv_on);
        compare_level("btb_ifctrl_inv_done", 1'b1, btb_ifctrl_inv_done);
        check_ways(exp);
        @(posedge refill_buf_updt_clk);
    endtask

    // One-cycle update strobe from the address generator
    task automatic send_update(input logic [INDEX_W-1:0] idx, input logic [TAG_W-1:0] new_tag,
                               input logic [TARGET_W-1:0] new_target);
        addrgen_btb_update_vld <= 1'b1;
        addrgen_btb_index      <= idx;
        addrgen_btb_update     <= '{tag: new_tag, target: new_target, pred: '0};
        @(posedge refill_buf_updt_clk);
        addrgen_btb_update_vld <= 1'b0;
    endtask

    // Stall here lands on the stage-one step
    task automatic pick_up_pred(input logic [PRED_W-1:0] pred, input logic stall);
        ipctrl_btb_way_pred <= pred;
        pcgen_btb_stall     <= stall;
        repeat (2) @(posedge refill_buf_updt_clk);
        pcgen_btb_stall     <= 1'b0;
    endtask

    task automatic send_miss();
        ibdp_btb_miss <= 1'b1;
        @(posedge refill_buf_updt_clk);
        ibdp_btb_miss <= 1'b0;
    endtask

    // Result one cycle after the read edge
    task automatic read_set(input logic [INDEX_W-1:0] idx, input btb_way_t [NUM_WAYS-1:0] exp);
        pcgen_btb_index <= idx;
        pcgen_btb_stall <= 1'b0;
        @(posedge refill_buf_updt_clk);
        @(negedge refill_buf_updt_clk);
        check_ways(exp);
        @(posedge refill_buf_updt_clk);
    endtask

    // Result must not move under stall with a moving fetch index
    task automatic hold_under_stall(input logic [INDEX_W-1:0] idx, input int cycles,
                                    input btb_way_t [NUM_WAYS-1:0] exp);
        pcgen_btb_stall <= 1'b1;
        pcgen_btb_index <= idx;
        for (int c = 0; c < cycles; c++) begin
            @(negedge refill_buf_updt_clk);
            check_ways(exp);
            @(posedge refill_buf_updt_clk);
            pcgen_btb_index <= idx + INDEX_W'(c + 1);
        end
        pcgen_btb_stall <= 1'b0;
    endtask

    task automatic set_enable(input logic en);
        cp0_ifu_btb_en <= en;
        @(posedge refill_buf_updt_clk);
    endtask

    // Strobe and wait for done with a cycle limit counted from the strobe
    task automatic invalidate_all();
        int waited;
        ifctrl_btb_inv <= 1'b1;
        @(posedge refill_buf_updt_clk);
        ifctrl_btb_inv <= 1'b0;
        @(negedge refill_buf_updt_clk);
        compare_level("btb_ifctrl_inv_on", 1'b1, btb_ifctrl_inv_on);
        compare_level("btb_ifctrl_inv_done", 1'b0, btb_ifctrl_inv_done);
        waited = 0;
        while (!btb_ifctrl_inv_done && waited < SETS + 1) begin
            @(negedge refill_buf_updt_clk);
            waited++;
        end
        if (!btb_ifctrl_inv_done) begin
            $display("Timeout: btb_ifctrl_inv_done not back within %0d cycles", SETS + 2);
            timed_out = 1'b1;
        end
        compare_level("btb_ifctrl_inv_on", 1'b0, btb_ifctrl_inv_on);
        compare_level("btb_ifctrl_inv_done", 1'b1, btb_ifctrl_inv_done);
        @(posedge refill_buf_updt_clk);
    endtask

    task automatic report_test();
        $display("Test %0d finished with %0d errors", cur_test, test_errors);
    endtask

    //==========================================================================
    //                          Main sequence
    //==========================================================================
    initial begin
        int                      fd;
        int                      nread;
        int                      tnum;
        string                   line;
        string                   op;
        logic [31:0]             f0;
        logic [31:0]             f1;
        logic [31:0]             f2;
        logic [31:0]             ev [NUM_WAYS];
        logic [31:0]             et [NUM_WAYS];
        logic [31:0]             ep [NUM_WAYS];
        logic [31:0]             eg [NUM_WAYS];
        btb_way_t [NUM_WAYS-1:0] exp_way;

        refill_buf_updt_clk    = 1'b0;
        cpurst_b               = 1'b0;
        cp0_ifu_btb_en         = 1'b1;
        // Stall keeps the unswept arrays from being read
        pcgen_btb_stall        = 1'b1;
        ibdp_btb_miss          = 1'b0;
        ifctrl_btb_inv         = 1'b0;
        addrgen_btb_update_vld = 1'b0;
        pcgen_btb_index        = '0;
        addrgen_btb_index      = '0;
        addrgen_btb_update     = '0;
        ipctrl_btb_way_pred    = '0;
        checks                 = 0;
        errors                 = 0;
        test_errors            = 0;
        cur_test               = 0;
        timed_out              = 1'b0;

        repeat (4) @(posedge refill_buf_updt_clk);
        cpurst_b <= 1'b1;
        @(posedge refill_buf_updt_clk);

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %s", VEC_FILE);
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                nread = $fgets(line, fd);
                if (nread > 1 && line.substr(0, 0) != "#") begin
                    nread = $sscanf(line,
                        "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        op, tnum, f0, f1, f2,
                        ev[0], et[0], ep[0], eg[0], ev[1], et[1], ep[1], eg[1],
                        ev[2], et[2], ep[2], eg[2], ev[3], et[3], ep[3], eg[3]);
                    if (nread != 21) begin
                        $display("Malformed vector line: %s", line);
                        errors++;
                    end else begin
                        for (int w = 0; w < NUM_WAYS; w++) begin
                            exp_way[w] = '{vld: ev[w][0], tag: et[w][TAG_W-1:0],
                                           pred: ep[w][PRED_W-1:0],
                                           target: eg[w][TARGET_W-1:0]};
                        end
                        // New test number closes the previous test
                        if (tnum != cur_test) begin
                            if (cur_test != 0) begin
                                report_test();
                            end
                            cur_test    = tnum;
                            test_errors = 0;
                        end
                        case (op)
                            "C": check_idle(exp_way);
                            "I": invalidate_all();
                            "U": send_update(f0[INDEX_W-1:0], f1[TAG_W-1:0], f2[TARGET_W-1:0]);
                            "P": pick_up_pred(f0[PRED_W-1:0], f1[0]);
                            "M": send_miss();
                            "R": read_set(f0[INDEX_W-1:0], exp_way);
                            "H": hold_under_stall(f0[INDEX_W-1:0], int'(f1), exp_way);
                            "E": set_enable(f0[0]);
                            default: begin
                                $display("Unknown operation %s in the vector file", op);
                                errors++;
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
        if (cur_test != 0) begin
            report_test();
        end

        $display("Checks %0d, mismatches %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/btb_assertions.sv
// Concurrent checks on the BTB control block
// Bound into every btb_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module btb_assertions #(
    parameter int INDEX_W = 10
) (
    input logic               refill_buf_updt_clk,
    input logic               cpurst_b,
    input logic               array_rd,
    input logic               inv_on,
    input logic               refill_vld,
    input btb_pkg::way_mask_t tag_wen,
    input logic [INDEX_W-1:0] inv_cnt
);

    // No array read while the sweep owns the arrays
    no_read_in_sweep: assert property (
        @(posedge refill_buf_updt_clk) disable iff (!cpurst_b)
        !(array_rd && inv_on)
    ) else $error("array_rd high while the invalidation sweep runs");

    // Miss write hits one way and only from a complete buffer
    one_way_miss_write: assert property (
        @(posedge refill_buf_updt_clk) disable iff (!cpurst_b)
        (!inv_on && (tag_wen != '0)) |-> ($onehot(tag_wen) && refill_vld)
    ) else $error("miss write mask not one-hot or refill buffer invalid");

    // Sweep ends only after set 0
    sweep_ends_at_zero: assert property (
        @(posedge refill_buf_updt_clk) disable iff (!cpurst_b)
        $fell(inv_on) |-> ($past(inv_cnt) == '0)
    ) else $error("inv_on fell before the sweep counter reached zero");

endmodule

bind btb_ctrl btb_assertions #(.INDEX_W(INDEX_W)) i_btb_assertions (
    .refill_buf_updt_clk (refill_buf_updt_clk),
    .cpurst_b            (cpurst_b),
    .array_rd            (array_rd),
    .inv_on              (inv_on),
    .refill_vld          (refill_vld),
    .tag_wen             (tag_wen),
    .inv_cnt             (inv_cnt)
);

`default_nettype wire

//--- logic/btb_top.sv
// Four-way branch target buffer for the instruction fetch unit
// Connects control, refill buffer, tag and data arrays and the output stage
`timescale 1ns/1ps
`default_nettype none

module btb_top #(
    parameter int INDEX_W = 10
) (
    input  logic                                      refill_buf_updt_clk,
    input  logic                                      cpurst_b,
    input  logic                                      cp0_ifu_btb_en,
    input  logic                                      pcgen_btb_stall,
    input  logic                                      ibdp_btb_miss,
    input  logic                                      ifctrl_btb_inv,
    input  logic                                      addrgen_btb_update_vld,
    input  logic [INDEX_W-1:0]                        pcgen_btb_index,
    input  logic [INDEX_W-1:0]                        addrgen_btb_index,
    input  btb_pkg::refill_t                          addrgen_btb_update,
    input  logic [btb_pkg::PRED_W-1:0]                ipctrl_btb_way_pred,
    output btb_pkg::btb_way_t [btb_pkg::NUM_WAYS-1:0] btb_ifdp_way,
    output logic                                      btb_ifctrl_inv_on,
    output logic                                      btb_ifctrl_inv_done
);

    import btb_pkg::*;

    logic                     inv_on;
    logic                     refill_vld;
    logic                     refill_take;
    logic [INDEX_W-1:0]       refill_index;
    refill_t                  refill_entry;
    logic [INDEX_W-1:0]       array_index;
    logic                     array_rd;
    way_mask_t                tag_wen;
    way_mask_t                data_wen;
    tag_way_t  [NUM_WAYS-1:0] tag_din;
    tag_way_t  [NUM_WAYS-1:0] tag_dout;
    data_way_t [NUM_WAYS-1:0] data_din;
    data_way_t [NUM_WAYS-1:0] data_dout;

    //==========================================================================
    //                     Control and refill buffer
    //==========================================================================
    btb_ctrl #(
        .INDEX_W (INDEX_W)
    ) i_btb_ctrl (
        .refill_buf_updt_clk (refill_buf_updt_clk),
        .cpurst_b            (cpurst_b),
        .cp0_ifu_btb_en      (cp0_ifu_btb_en),
        .pcgen_btb_stall     (pcgen_btb_stall),
        .ibdp_btb_miss       (ibdp_btb_miss),
        .ifctrl_btb_inv      (ifctrl_btb_inv),
        .pcgen_btb_index     (pcgen_btb_index),
        .refill_vld          (refill_vld),
        .refill_index        (refill_index),
        .refill_entry        (refill_entry),
        .array_index         (array_index),
        .array_rd            (array_rd),
        .tag_wen             (tag_wen),
        .data_wen            (data_wen),
        .tag_din             (tag_din),
        .data_din            (data_din),
        .refill_take         (refill_take),
        .inv_on              (inv_on)
    );

    btb_refill_buf #(
        .INDEX_W (INDEX_W)
    ) i_btb_refill_buf (
        .refill_buf_updt_clk    (refill_buf_updt_clk),
        .cpurst_b               (cpurst_b),
        .cp0_ifu_btb_en         (cp0_ifu_btb_en),
        .addrgen_btb_update_vld (addrgen_btb_update_vld),
        .addrgen_btb_index      (addrgen_btb_index),
        .addrgen_btb_update     (addrgen_btb_update),
        .ipctrl_btb_way_pred    (ipctrl_btb_way_pred),
        .pcgen_btb_stall        (pcgen_btb_stall),
        .inv_on                 (inv_on),
        .refill_take            (refill_take),
        .refill_vld             (refill_vld),
        .refill_index           (refill_index),
        .refill_entry           (refill_entry)
    );

    //==========================================================================
    //                         Tag and data arrays
    //==========================================================================
    btb_way_array #(
        .INDEX_W (INDEX_W),
        .T_WAY   (tag_way_t)
    ) i_tag_array (
        .refill_buf_updt_clk (refill_buf_updt_clk),
        .index               (array_index),
        .rd                  (array_rd),
        .wen                 (tag_wen),
        .din                 (tag_din),
        .dout                (tag_dout)
    );

    btb_way_array #(
        .INDEX_W (INDEX_W),
        .T_WAY   (data_way_t)
    ) i_data_array (
        .refill_buf_updt_clk (refill_buf_updt_clk),
        .index               (array_index),
        .rd                  (array_rd),
        .wen                 (data_wen),
        .din                 (data_din),
        .dout                (data_dout)
    );

    // Lookup result towards the fetch datapath
    btb_read_out i_btb_read_out (
        .refill_buf_updt_clk (refill_buf_updt_clk),
        .cpurst_b            (cpurst_b),
        .array_rd            (array_rd),
        .inv_on              (inv_on),
        .cp0_ifu_btb_en      (cp0_ifu_btb_en),
        .tag_dout            (tag_dout),
        .data_dout           (data_dout),
        .btb_ifdp_way        (btb_ifdp_way)
    );

    assign btb_ifctrl_inv_on   = inv_on;
    assign btb_ifctrl_inv_done = !inv_on;

endmodule

`default_nettype wire

//--- logic/btb_read_out.sv
// Output stage of the BTB lookup: live array rows right after a read,
// held rows otherwise, merged per way and masked by the global enable
`timescale 1ns/1ps
`default_nettype none

module btb_read_out (
    input  logic                                       refill_buf_updt_clk,
    input  logic                                       cpurst_b,
    input  logic                                       array_rd,
    input  logic                                       inv_on,
    input  logic                                       cp0_ifu_btb_en,
    input  btb_pkg::tag_way_t  [btb_pkg::NUM_WAYS-1:0] tag_dout,
    input  btb_pkg::data_way_t [btb_pkg::NUM_WAYS-1:0] data_dout,
    output btb_pkg::btb_way_t  [btb_pkg::NUM_WAYS-1:0] btb_ifdp_way
);

    import btb_pkg::*;

    logic                         rd_flop;
    tag_way_t  [NUM_WAYS-1:0]     tag_hold;
    data_way_t [NUM_WAYS-1:0]     data_hold;
    tag_way_t  [NUM_WAYS-1:0]     tag_sel;
    data_way_t [NUM_WAYS-1:0]     data_sel;

    // Set the cycle the array row is fresh
    always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            rd_flop <= 1'b0;
        end else if (inv_on) begin
            rd_flop <= 1'b0;
        end else begin
            rd_flop <= array_rd;
        end
    end

    //==========================================================================
    //                          Hold registers
    //==========================================================================
    // Keeps the last read across stalls and writes
    always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            tag_hold  <= '0;
            data_hold <= '0;
        end else if (inv_on) begin
            tag_hold  <= '0;
            data_hold <= '0;
        end else if (rd_flop) begin
            tag_hold  <= tag_dout;
            data_hold <= data_dout;
        end
    end

    assign tag_sel  = rd_flop ? tag_dout  : tag_hold;
    assign data_sel = rd_flop ? data_dout : data_hold;

    // Per-way merge, valid masked when the BTB is off
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            btb_ifdp_way[w].vld    = tag_sel[w].vld && cp0_ifu_btb_en;
            btb_ifdp_way[w].tag    = tag_sel[w].tag;
            btb_ifdp_way[w].pred   = data_sel[w].pred;
            btb_ifdp_way[w].target = data_sel[w].target;
        end
    end

endmodule

`default_nettype wire

//--- logic/btb_way_array.sv
// Set-associative storage with per-way write and registered whole-row read
// One instance holds the tag ways, another the data ways
`timescale 1ns/1ps
`default_nettype none

module btb_way_array #(
    parameter int  INDEX_W = 10,
    parameter type T_WAY   = btb_pkg::tag_way_t
) (
    input  logic                          refill_buf_updt_clk,
    input  logic [INDEX_W-1:0]            index,
    input  logic                          rd,
    input  btb_pkg::way_mask_t            wen,
    input  T_WAY [btb_pkg::NUM_WAYS-1:0]  din,
    output T_WAY [btb_pkg::NUM_WAYS-1:0]  dout
);

    import btb_pkg::*;

    localparam int DEPTH = 2 ** INDEX_W;

    //==========================================================================
    //                          One bank per way
    //==========================================================================
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        T_WAY mem [DEPTH];

        // Write only the enabled way
        always_ff @(posedge refill_buf_updt_clk) begin
            if (wen[w]) begin
                mem[index] <= din[w];
            end
        end

        // Read result stays until the next read
        always_ff @(posedge refill_buf_updt_clk) begin
            if (rd) begin
                dout[w] <= mem[index];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/btb_refill_buf.sv
// Refill buffer holding the last branch target update from the address
// generator, completed with the icache way prediction two cycles later
`timescale 1ns/1ps
`default_nettype none

module btb_refill_buf #(
    parameter int INDEX_W = 10
) (
    input  logic                        refill_buf_updt_clk,
    input  logic                        cpurst_b,
    input  logic                        cp0_ifu_btb_en,
    input  logic                        addrgen_btb_update_vld,
    input  logic [INDEX_W-1:0]          addrgen_btb_index,
    input  btb_pkg::refill_t            addrgen_btb_update,
    input  logic [btb_pkg::PRED_W-1:0]  ipctrl_btb_way_pred,
    input  logic                        pcgen_btb_stall,
    input  logic                        inv_on,
    input  logic                        refill_take,
    output logic                        refill_vld,
    output logic [INDEX_W-1:0]          refill_index,
    output btb_pkg::refill_t            refill_entry
);

    import btb_pkg::*;

    logic                capture;
    logic                stage_one;
    logic                stage_two;
    logic [TAG_W-1:0]    buf_tag;
    logic [TARGET_W-1:0] buf_target;
    logic [PRED_W-1:0]   buf_pred;

    assign capture = cp0_ifu_btb_en && addrgen_btb_update_vld;

    //==========================================================================
    //                     Way prediction pickup chain
    //==========================================================================
    // Stall at the stage-one step loses the pickup
    always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            stage_one <= 1'b0;
            stage_two <= 1'b0;
        end else if (inv_on) begin
            stage_one <= 1'b0;
            stage_two <= 1'b0;
        end else begin
            stage_one <= capture;
            stage_two <= stage_one && !pcgen_btb_stall;
        end
    end

    // Index, tag and target from the update strobe
    always_ff @(posedge refill_buf_updt_clk) begin
        if (inv_on) begin
            refill_index <= '0;
            buf_tag      <= '0;
            buf_target   <= '0;
        end else if (capture) begin
            refill_index <= addrgen_btb_index;
            buf_tag      <= addrgen_btb_update.tag;
            buf_target   <= addrgen_btb_update.target;
        end
    end

    // Prediction sampled while stage two is set
    always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            buf_pred <= PRED_RESET;
        end else if (inv_on) begin
            buf_pred <= PRED_RESET;
        end else if (stage_two) begin
            buf_pred <= ipctrl_btb_way_pred;
        end
    end

    // Valid once complete, gone after a new capture or the array write
    always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            refill_vld <= 1'b0;
        end else if (inv_on || capture) begin
            refill_vld <= 1'b0;
        end else if (stage_two) begin
            refill_vld <= 1'b1;
        end else if (refill_take) begin
            refill_vld <= 1'b0;
        end
    end

    assign refill_entry = '{tag: buf_tag, target: buf_target, pred: buf_pred};

endmodule

`default_nettype wire

//--- logic/btb_ctrl.sv
// BTB control: invalidation sweep, array index priority, read strobe
// and the per-way write masks and write rows for both arrays
`timescale 1ns/1ps
`default_nettype none

module btb_ctrl #(
    parameter int INDEX_W = 10
) (
    input  logic                                       refill_buf_updt_clk,
    input  logic                                       cpurst_b,
    input  logic                                       cp0_ifu_btb_en,
    input  logic                                       pcgen_btb_stall,
    input  logic                                       ibdp_btb_miss,
    input  logic                                       ifctrl_btb_inv,
    input  logic [INDEX_W-1:0]                         pcgen_btb_index,
    input  logic                                       refill_vld,
    input  logic [INDEX_W-1:0]                         refill_index,
    input  btb_pkg::refill_t                           refill_entry,
    output logic [INDEX_W-1:0]                         array_index,
    output logic                                       array_rd,
    output btb_pkg::way_mask_t                         tag_wen,
    output btb_pkg::way_mask_t                         data_wen,
    output btb_pkg::tag_way_t  [btb_pkg::NUM_WAYS-1:0] tag_din,
    output btb_pkg::data_way_t [btb_pkg::NUM_WAYS-1:0] data_din,
    output logic                                       refill_take,
    output logic                                       inv_on
);

    import btb_pkg::*;

    // Bits of the tag that pick the write way
    localparam int WAY_W = $clog2(NUM_WAYS);

    logic [INDEX_W-1:0] inv_cnt;
    logic               miss_wr;
    way_mask_t          way_sel;

    //==========================================================================
    //                         Invalidation sweep
    //==========================================================================
    // Counter walks from the top set down to set 0
    always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            inv_cnt <= '0;
        end else if (inv_on) begin
            inv_cnt <= inv_cnt - 1'b1;
        end else if (ifctrl_btb_inv) begin
            inv_cnt <= '1;
        end
    end

    // Drops the cycle after set 0 has been cleared
    always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            inv_on <= 1'b0;
        end else if (inv_on && (inv_cnt == '0)) begin
            inv_on <= 1'b0;
        end else if (ifctrl_btb_inv) begin
            inv_on <= 1'b1;
        end
    end

    //==========================================================================
    //                     Index, read strobe, write
    //==========================================================================
    // Miss write only with a complete buffer entry
    assign miss_wr     = cp0_ifu_btb_en && ibdp_btb_miss && refill_vld && !inv_on;
    assign refill_take = miss_wr;

    // Sweep first, then miss write, then sequential fetch index
    assign array_index = inv_on  ? inv_cnt      :
                         miss_wr ? refill_index : pcgen_btb_index;

    // Arrays read only when nothing writes them
    assign array_rd = cp0_ifu_btb_en && !pcgen_btb_stall && !inv_on && !miss_wr;

    // One-hot way from tag bits 2:1
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_sel[w] = (refill_entry.tag[WAY_W:1] == WAY_W'(w));
        end
    end

    // Sweep hits all ways, miss write one way
    assign tag_wen  = inv_on ? '1 : (miss_wr ? way_sel : '0);
    assign data_wen = tag_wen;

    // Same row content offered to every way, the mask picks
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (inv_on) begin
                tag_din[w]  = '0;
                data_din[w] = '0;
            end else begin
                tag_din[w]  = '{vld: 1'b1, tag: refill_entry.tag};
                data_din[w] = '{pred: refill_entry.pred, target: refill_entry.target};
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/btb_pkg.sv
// Field widths, way count and packed structs of the branch target buffer
// Shared by every RTL block and by the testbench
`default_nettype none

package btb_pkg;

    // Ways per set, the write-way decode uses tag bits 2:1
    localparam int NUM_WAYS = 4;
    localparam int TAG_W    = 10;
    localparam int TARGET_W = 20;
    localparam int PRED_W   = 2;

    // Way prediction of an empty refill buffer
    localparam logic [PRED_W-1:0] PRED_RESET = '1;

    // One way of the tag array
    typedef struct packed {
        logic             vld;
        logic [TAG_W-1:0] tag;
    } tag_way_t;

    // One way of the data array
    typedef struct packed {
        logic [PRED_W-1:0]   pred;
        logic [TARGET_W-1:0] target;
    } data_way_t;

    // One way of lookup result towards the fetch datapath
    typedef struct packed {
        logic                vld;
        logic [TAG_W-1:0]    tag;
        logic [PRED_W-1:0]   pred;
        logic [TARGET_W-1:0] target;
    } btb_way_t;

    // Per-way write enable, active high
    typedef logic [NUM_WAYS-1:0] way_mask_t;

    // Refill buffer payload, index kept apart
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [TARGET_W-1:0] target;
        logic [PRED_W-1:0]   pred;
    } refill_t;

endpackage

`default_nettype wire
